// File: line_threat_finder.sv
module line_threat_finder (
	// cells holding the side of interest
	input  ttt_pkg::cell_map_t marks,
	// cells holding either side
	input  ttt_pkg::cell_map_t occupied,
	// lowest completing cell, if any
	output ttt_pkg::pick_t     threat
);

	import ttt_pkg::*;

	// every empty cell that would complete some line
	cell_map_t gap_map;

	// walk all lines, try each position as the gap
	always_comb
	begin
		cell_idx_t gap;
		cell_idx_t side_a;
		cell_idx_t side_b;

		gap_map = '0;
		for (int l = 0; l < LINE_COUNT; l++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				// gap plus the two other cells of the line
				gap    = LINE_TABLE[l][k];
				side_a = LINE_TABLE[l][(k + 1) % 3];
				side_b = LINE_TABLE[l][(k + 2) % 3];

				// two marked, third still free
				if (marks[side_a] && marks[side_b] && !occupied[gap])
				begin
					gap_map[gap] = 1'b1;
				end
			end
		end
	end

	// a cell may close more than one line
	// so gap_map can carry several bits

	// isolate lowest set bit, x & -x
	// gives lowest cell index first
	assign threat.move  = gap_map & (~gap_map + cell_map_t'(1));

	// any candidate at all
	assign threat.found = |gap_map;

endmodule

// File: move_selector.sv
module move_selector (
	input  logic               clk,
	input  logic               rst_n,
	// candidates from the finders and the picker
	input  ttt_pkg::pick_t     win,
	input  ttt_pkg::pick_t     block,
	input  ttt_pkg::pick_t     open,
	// opponent marks, for the opening reply
	input  ttt_pkg::cell_map_t opp_marks,
	// 1 = hard, 0 = easy
	input  logic               mode,
	input  logic               ai_en,
	input  logic [3:0]         move_count,
	output ttt_pkg::move_t     ai_move
);

	import ttt_pkg::*;

	// combinational choice from this cycle's inputs
	move_t choice;
	// registered move
	move_t move_q;

	always_comb
	begin
		if (move_count == OPENING_COUNT)
		begin
			// corner if the opponent took the center
			if (opp_marks[CENTER_CELL])
			begin
				choice = move_t'(1) << CORNER_REPLY_CELL;
			end
			else
			begin
				choice = move_t'(1) << CENTER_CELL;
			end
		end
		else if (mode)
		begin
			// win first, then block, then fallback scan
			if (win.found)
			begin
				choice = win.move;
			end
			else if (block.found)
			begin
				choice = block.move;
			end
			else if (open.found)
			begin
				choice = open.move;
			end
			else
			begin
				choice = '0;
			end
		end
		else
		begin
			// easy mode ignores threats
			choice = open.found ? open.move : '0;
		end
	end

	// load while enabled, clear while not
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			move_q <= '0;
		end
		else if (ai_en)
		begin
			move_q <= choice;
		end
		else
		begin
			move_q <= '0;
		end
	end

	// drop the move as soon as ai_en falls
	assign ai_move = ai_en ? move_q : '0;

	// never more than one cell at a time
	a_move_onehot0 : assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(ai_move)
	)
	else
	begin
		$error("move_selector: ai_move %b not one-hot", ai_move);
	end

	// no move shown while disabled
	a_move_gated : assert property (
		@(posedge clk) disable iff (!rst_n)
		!ai_en |-> (ai_move == '0)
	)
	else
	begin
		$error("move_selector: ai_move %b with ai_en low", ai_move);
	end

endmodule

// File: open_cell_picker.sv
module open_cell_picker (
	input  logic               clk,
	input  logic               rst_n,
	// cells holding either side
	input  ttt_pkg::cell_map_t occupied,
	// 1 = hard, 0 = easy
	input  logic               mode,
	// first free cell in the active order
	output ttt_pkg::pick_t     pick
);

	import ttt_pkg::*;

	// free-running rotation, selects the hard-mode order
	logic [1:0] rot_cnt;

	// scan order for this cycle
	cell_idx_t order [CELL_COUNT];

	// counts every edge, ai_en plays no part
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rot_cnt <= 2'd0;
		end
		else
		begin
			rot_cnt <= rot_cnt + 2'd1;
		end
	end

	// hard mode uses a preference row
	// easy mode is plain index order
	always_comb
	begin
		for (int i = 0; i < CELL_COUNT; i++)
		begin
			if (mode)
			begin
				order[i] = PREF_ORDERS[rot_cnt][i];
			end
			else
			begin
				order[i] = cell_idx_t'(i);
			end
		end
	end

	// scan back to front so the earliest free entry wins
	always_comb
	begin
		pick = '0;
		for (int i = CELL_COUNT - 1; i >= 0; i--)
		begin
			if (!occupied[order[i]])
			begin
				pick.found = 1'b1;
				pick.move  = move_t'(1) << order[i];
			end
		end
	end

	// full board leaves found clear and move zero

	// a found pick names exactly one free cell
	a_pick_free_onehot : assert property (
		@(posedge clk) disable iff (!rst_n)
		pick.found |-> ($onehot(pick.move) && ((pick.move & occupied) == '0))
	)
	else
	begin
		$error("open_cell_picker: bad pick %b for occupancy %b", pick.move, occupied);
	end

endmodule

// File: ttt_ai.f
+incdir+.
ttt_pkg.sv
line_threat_finder.sv
open_cell_picker.sv
move_selector.sv
ttt_ai.sv
ttt_ai_tb.sv

// File: ttt_ai.sv
module ttt_ai (
	input  logic            clk,
	input  logic            rst_n,
	input  ttt_pkg::board_t board,
	input  logic            ai_en,
	// 1 = hard, 0 = easy
	input  logic            mode,
	input  logic [3:0]      move_count,
	output ttt_pkg::move_t  ai_move
);

	import ttt_pkg::*;

	// per-side and combined cell maps
	cell_map_t own_map;
	cell_map_t opp_map;
	cell_map_t occ_map;

	// candidate picks
	pick_t win_pick;
	pick_t block_pick;
	pick_t open_pick;

	// split the board into flat maps
	for (genvar k = 0; k < CELL_COUNT; k++)
	begin : g_split
		assign own_map[k] = board[k].own;
		assign opp_map[k] = board[k].opp;
	end

	assign occ_map = own_map | opp_map;

	// our own two-in-a-row
	line_threat_finder win_finder (
		.marks    (own_map),
		.occupied (occ_map),
		.threat   (win_pick)
	);

	// opponent two-in-a-row
	line_threat_finder block_finder (
		.marks    (opp_map),
		.occupied (occ_map),
		.threat   (block_pick)
	);

	open_cell_picker open_cell_picker_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.occupied (occ_map),
		.mode     (mode),
		.pick     (open_pick)
	);

	move_selector move_selector_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.win        (win_pick),
		.block      (block_pick),
		.open       (open_pick),
		.opp_marks  (opp_map),
		.mode       (mode),
		.ai_en      (ai_en),
		.move_count (move_count),
		.ai_move    (ai_move)
	);

endmodule

// File: ttt_ai_tb_ref.svh
// which rule an expectation came from
localparam logic [2:0] KIND_OFF      = 3'd0;
localparam logic [2:0] KIND_OPENING  = 3'd1;
localparam logic [2:0] KIND_THREAT   = 3'd2;
localparam logic [2:0] KIND_FALLBACK = 3'd3;
localparam logic [2:0] KIND_EASY     = 3'd4;

// bit k is cell k
localparam cell_map_t CENTER_MASK = 9'b000010000;
localparam cell_map_t CORNER_MASK = 9'b101000101;
localparam cell_map_t EDGE_MASK   = 9'b010101010;

// rows, columns, diagonals as cell masks
localparam cell_map_t LINE_MASKS [8] = '{
	9'b000000111, 9'b000111000, 9'b111000000,
	9'b001001001, 9'b010010010, 9'b100100100,
	9'b100010001, 9'b001010100
};

// rule tag plus the set of acceptable cells
typedef struct packed {
	logic [2:0] kind;
	move_t      allowed;
} expect_t;

function automatic int unsigned lcg_next(input int unsigned s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// lowest set cell as one-hot, zero if none
function automatic move_t lowest_cell(input cell_map_t m);
	move_t res;
	res = '0;
	for (int k = 8; k >= 0; k--)
	begin
		if (m[k])
		begin
			res = move_t'(1) << k;
		end
	end
	return res;
endfunction

// empty cell closing a line of two marks
function automatic move_t threat_gap(input cell_map_t marks, input cell_map_t occ);
	cell_map_t gaps;
	gaps = '0;
	for (int l = 0; l < 8; l++)
	begin
		// two of ours plus one free cell
		if ($countones(marks & LINE_MASKS[l]) == 2 && $countones(occ & LINE_MASKS[l]) == 2)
		begin
			gaps = gaps | (LINE_MASKS[l] & ~occ);
		end
	end
	return lowest_cell(gaps);
endfunction

function automatic board_t board_from(input cell_map_t own, input cell_map_t opp);
	board_t b;
	for (int k = 0; k < 9; k++)
	begin
		b[k].own = own[k];
		b[k].opp = opp[k];
	end
	return b;
endfunction

// no double-flagged cell, sides at most one apart
function automatic logic legal_board(input board_t b);
	int own_n;
	int opp_n;
	own_n = 0;
	opp_n = 0;
	for (int k = 0; k < 9; k++)
	begin
		if (b[k].own && b[k].opp)
		begin
			return 1'b0;
		end
		own_n += int'(b[k].own);
		opp_n += int'(b[k].opp);
	end
	return (own_n - opp_n <= 1) && (opp_n - own_n <= 1);
endfunction

function automatic expect_t expected_move(input board_t b, input logic hard,
		input logic [3:0] cnt, input logic en);
	cell_map_t own;
	cell_map_t opp;
	cell_map_t empty;
	expect_t e;
	for (int k = 0; k < 9; k++)
	begin
		own[k] = b[k].own;
		opp[k] = b[k].opp;
	end
	empty = ~(own | opp);
	e = '{kind: KIND_OFF, allowed: '0};
	if (!en)
	begin
		return e;
	end
	if (cnt == 4'd1)
	begin
		// C3 against a center opening, else take the center
		e.kind    = KIND_OPENING;
		e.allowed = opp[4] ? 9'b100000000 : CENTER_MASK;
	end
	else if (!hard)
	begin
		e.kind    = KIND_EASY;
		e.allowed = lowest_cell(empty);
	end
	else if (threat_gap(own, own | opp) != '0)
	begin
		e.kind    = KIND_THREAT;
		e.allowed = threat_gap(own, own | opp);
	end
	else if (threat_gap(opp, own | opp) != '0)
	begin
		e.kind    = KIND_THREAT;
		e.allowed = threat_gap(opp, own | opp);
	end
	else
	begin
		// any rotation is fine, only the class matters
		e.kind = KIND_FALLBACK;
		if (empty[4])
			e.allowed = CENTER_MASK;
		else if ((empty & CORNER_MASK) != '0)
			e.allowed = empty & CORNER_MASK;
		else
			e.allowed = empty & EDGE_MASK;
	end
	return e;
endfunction

// File: ttt_ai_tb.sv
module ttt_ai_tb;

	import ttt_pkg::*;

	`include "ttt_ai_tb_ref.svh"

	localparam int N_RANDOM    = 400;
	// reset, directed cases, random cases, drain
	localparam int STIM_CYCLES = 5 + 16 + N_RANDOM + 4;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

	logic       clk = 1'b0;
	logic       rst_n;
	board_t     board;
	logic       ai_en;
	logic       mode;
	logic [3:0] move_count;
	move_t      ai_move;

	// expectation from the previous rising edge
	expect_t     exp_q;
	int unsigned seed = 5007;
	int          mismatch_cnt = 0;
	int          fail_cnt = 0;
	int          cycle_cnt = 0;
	// checks reached per rule kind
	int          hits [5];

	always #5 clk = ~clk;

	ttt_ai ttt_ai_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.board      (board),
		.ai_en      (ai_en),
		.mode       (mode),
		.move_count (move_count),
		.ai_move    (ai_move)
	);

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			exp_q <= '{kind: KIND_OFF, allowed: '0};
		end
		else
		begin
			hits[ai_en ? exp_q.kind : KIND_OFF]++;
			exp_q <= expected_move(board, mode, move_count, ai_en);
		end
	end

	task automatic log_mismatch(input move_t expected, input move_t actual);
		mismatch_cnt++;
		$display("MISMATCH time=%0t signal=ai_move expected=%b actual=%b",
			$time, expected, actual);
	endtask

	task automatic print_counts();
		$display("mismatches=%0d other_failures=%0d", mismatch_cnt, fail_cnt);
	endtask

	// enable gating, also right after reset
	a_gated : assert property (@(posedge clk) disable iff (!rst_n)
		(!ai_en || exp_q.kind == KIND_OFF) |-> (ai_move == '0))
		else log_mismatch('0, $sampled(ai_move));

	a_opening : assert property (@(posedge clk) disable iff (!rst_n)
		(ai_en && exp_q.kind == KIND_OPENING) |-> (ai_move == exp_q.allowed))
		else log_mismatch($sampled(exp_q.allowed), $sampled(ai_move));

	// win before block, lowest cell
	a_threat : assert property (@(posedge clk) disable iff (!rst_n)
		(ai_en && exp_q.kind == KIND_THREAT) |-> (ai_move == exp_q.allowed))
		else log_mismatch($sampled(exp_q.allowed), $sampled(ai_move));

	// one cell out of the allowed class, zero when full
	a_fallback : assert property (@(posedge clk) disable iff (!rst_n)
		(ai_en && exp_q.kind == KIND_FALLBACK) |->
		((exp_q.allowed == '0) ? (ai_move == '0) :
		($onehot(ai_move) && ((ai_move & ~exp_q.allowed) == '0))))
		else log_mismatch($sampled(exp_q.allowed), $sampled(ai_move));

	a_easy : assert property (@(posedge clk) disable iff (!rst_n)
		(ai_en && exp_q.kind == KIND_EASY) |-> (ai_move == exp_q.allowed))
		else log_mismatch($sampled(exp_q.allowed), $sampled(ai_move));

	// hang guard
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			fail_cnt++;
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			print_counts();
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic drive(input board_t b, input logic hard, input logic [3:0] cnt,
			input logic en);
		@(negedge clk);
		board      = b;
		mode       = hard;
		move_count = cnt;
		ai_en      = en;
	endtask

	task automatic run_case(input cell_map_t own, input cell_map_t opp, input logic hard,
			input logic [3:0] cnt);
		drive(board_from(own, opp), hard, cnt, 1'b1);
	endtask

	// two random flag bits per cell
	// redraw on double marks or uneven sides
	task automatic random_case();
		board_t b;
		int     n;
		do
		begin
			n = 0;
			for (int k = 0; k < 9; k++)
			begin
				seed = lcg_next(seed);
				b[k] = seed[29:28];
				if (b[k].own || b[k].opp)
					n++;
			end
		end
		while (!legal_board(b));
		seed = lcg_next(seed);
		drive(b, seed[20], 4'(n), ((seed >> 16) % 8) != 0);
	endtask

	initial
	begin
		rst_n      = 1'b0;
		board      = '0;
		ai_en      = 1'b0;
		mode       = 1'b0;
		move_count = 4'd0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// opening against center, then against a corner
		run_case(9'b000000000, 9'b000010000, 1'b1, 4'd1);
		run_case(9'b000000000, 9'b000000001, 1'b0, 4'd1);
		// win at A3 beats block at B3
		run_case(9'b000000011, 9'b000011000, 1'b1, 4'd4);
		// block at B3
		run_case(9'b100000001, 9'b000011000, 1'b1, 4'd4);
		// fallback center, corner, edge, full
		run_case(9'b000000001, 9'b100000000, 1'b1, 4'd2);
		run_case(9'b000000001, 9'b000010000, 1'b1, 4'd2);
		run_case(9'b100000001, 9'b001010100, 1'b1, 4'd5);
		run_case(9'b011100101, 9'b100011010, 1'b1, 4'd9);
		// easy mode ignores the open win at B3
		run_case(9'b000011000, 9'b100000001, 1'b0, 4'd4);
		run_case(9'b011100101, 9'b100011010, 1'b0, 4'd9);
		// enable drop and return
		drive(board_from(9'b000000001, 9'b100000000), 1'b1, 4'd2, 1'b0);
		drive(board_from(9'b000000001, 9'b100000000), 1'b1, 4'd2, 1'b1);
		drive(board_from(9'b000000001, 9'b100000000), 1'b1, 4'd2, 1'b1);

		repeat (N_RANDOM) random_case();
		drive('0, 1'b0, 4'd0, 1'b0);
		drive('0, 1'b0, 4'd0, 1'b0);
		@(negedge clk);

		for (int k = 0; k < 5; k++)
		begin
			if (hits[k] == 0)
			begin
				fail_cnt++;
				$display("no stimulus reached the check for rule kind %0d", k);
			end
		end
		print_counts();
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: ttt_pkg.sv
package ttt_pkg;

	// board geometry
	localparam int CELL_COUNT = 9;
	localparam int LINE_COUNT = 8;

	// cells numbered row by row
	// A1=0 A2=1 A3=2 / B1=3 B2=4 B3=5 / C1=6 C2=7 C3=8
	typedef logic [3:0] cell_idx_t;

	// per-cell flags, both clear means empty
	// own sits in bit 1, opp in bit 0
	typedef struct packed {
		logic own;
		logic opp;
	} cell_t;

	// index 0 is A1
	typedef cell_t [CELL_COUNT-1:0] board_t;

	// one flag per cell, marks or occupancy
	typedef logic [CELL_COUNT-1:0] cell_map_t;

	// one-hot move, all zero for no move
	typedef logic [CELL_COUNT-1:0] move_t;

	// candidate move with a valid flag
	typedef struct packed {
		logic  found;
		move_t move;
	} pick_t;

	// opening reply cells
	localparam cell_idx_t  CENTER_CELL       = 4'd4;
	localparam cell_idx_t  CORNER_REPLY_CELL = 4'd8;
	localparam logic [3:0] OPENING_COUNT     = 4'd1;

	// all eight winning lines
	localparam cell_idx_t LINE_TABLE [LINE_COUNT][3] = '{
		// rows
		'{0, 1, 2},
		'{3, 4, 5},
		'{6, 7, 8},
		// columns
		'{0, 3, 6},
		'{1, 4, 7},
		'{2, 5, 8},
		// diagonals
		'{0, 4, 8},
		'{2, 4, 6}
	};

	// fallback orders, center then corners then edges
	// row picked by the rotation counter
	localparam cell_idx_t PREF_ORDERS [4][CELL_COUNT] = '{
		'{4, 0, 2, 8, 6, 3, 5, 1, 7},
		'{4, 2, 6, 0, 8, 3, 5, 1, 7},
		'{4, 6, 0, 8, 2, 1, 7, 3, 5},
		'{4, 8, 2, 6, 0, 1, 3, 5, 7}
	};

endpackage
